//--- flist.f
common/read_datapath_pkg.sv
design/read_latency_fifo.sv
design/oct_control.sv
read_fifo/valid_predict_fifo.sv
read_fifo/read_resync_fifo.sv
design/read_datapath.sv
sim/read_datapath_props.sv
sim/tb_read_datapath.sv

//--- run_sim.sh
#!/bin/sh
# Compile with Verilator and run from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_read_datapath -f flist.f -o tb_read_datapath \
	&& ./obj_dir/tb_read_datapath > sim.log 2>&1
cat sim.log 2>/dev/null

# Pass only if the log holds the pass line
grep -qx "sim passed" sim.log && echo "PASS" && exit 0 || echo "FAIL" && exit 1

//--- sim/tb_read_datapath.sv
// Latency and vfifo wrap changes are only applied while no request of another latency is in flight
`default_nettype none
`timescale 1ns/1ps

module tb_read_datapath;

	import read_datapath_pkg::*;

	localparam int NUM_ROWS = 9;
	localparam int EDGE_SLOTS = 1024;
	localparam int VFIFO_SPAN = 2 ** VFIFO_ADDR_WIDTH;

	logic pll_afi_clk;
	logic reset_n_afi_clk;
	dqs_vec_t read_capture_clk_i;
	dqs_vec_t seq_read_fifo_reset_i;
	lat_cnt_t seq_read_latency_counter_i;
	dqs_vec_t seq_read_increment_vfifo_i;
	logic afi_rdata_en_i;
	logic afi_rdata_en_full_i;
	ddio_data_t ddio_phy_dq_i;
	afi_data_t afi_rdata_o;
	logic afi_rdata_valid_o;
	afi_data_t phy_mux_read_fifo_q_o;
	dqs_vec_t dqs_enable_ctrl_o;
	logic force_oct_off_o;

	// Stimulus table, one row per test
	string row_name [NUM_ROWS];
	int row_lat [NUM_ROWS];
	int row_burst [NUM_ROWS];
	int row_inc0 [NUM_ROWS];
	int row_inc1 [NUM_ROWS];
	int row_gap [NUM_ROWS];
	// Expected DQS enable delay per group after the row's increments, worked out by hand
	int row_delay0 [NUM_ROWS];
	int row_delay1 [NUM_ROWS];
	int row_cnt = 0;

	// Expected outputs after each AFI edge, indexed by edge number
	logic exp_valid [EDGE_SLOTS];
	dqs_vec_t exp_dqs [EDGE_SLOTS];
	logic oct_low [EDGE_SLOTS];

	// Reference model state
	ddio_group_t model_mem [DQS_GROUPS][READ_FIFO_DEPTH];
	ddio_group_t snap [DQS_GROUPS];
	int rd_ptr_m [DQS_GROUPS];
	int wr_ptr_m [DQS_GROUPS];
	logic wr_rst_n_m [DQS_GROUPS];
	int vfifo_addr [DQS_GROUPS];

	int edge_cnt = 0;
	int cycle_cnt = 0;
	int cycle_limit = 100;
	int request_total = 0;
	int valid_seen = 0;
	int seed;
	string cur_name = "reset";

	read_datapath read_datapath_i (
		.pll_afi_clk                (pll_afi_clk),
		.reset_n_afi_clk            (reset_n_afi_clk),
		.read_capture_clk_i         (read_capture_clk_i),
		.seq_read_fifo_reset_i      (seq_read_fifo_reset_i),
		.seq_read_latency_counter_i (seq_read_latency_counter_i),
		.seq_read_increment_vfifo_i (seq_read_increment_vfifo_i),
		.afi_rdata_en_i             (afi_rdata_en_i),
		.afi_rdata_en_full_i        (afi_rdata_en_full_i),
		.ddio_phy_dq_i              (ddio_phy_dq_i),
		.afi_rdata_o                (afi_rdata_o),
		.afi_rdata_valid_o          (afi_rdata_valid_o),
		.phy_mux_read_fifo_q_o      (phy_mux_read_fifo_q_o),
		.dqs_enable_ctrl_o          (dqs_enable_ctrl_o),
		.force_oct_off_o            (force_oct_off_o)
	);

	// ****************************************
	// Clocks
	// ****************************************

	initial
	begin
		pll_afi_clk = 1'b0;
		forever #5 pll_afi_clk = ~pll_afi_clk;
	end

	// Capture clocks trail the AFI clock by a quarter period
	initial
	begin
		read_capture_clk_i = '0;
		#2.5;
		forever #5 read_capture_clk_i = ~read_capture_clk_i;
	end

	// ****************************************
	// Failure reporting
	// ****************************************

	task automatic fail_run(input string msg);
		$display("%0s", msg);
		$display("sim failed");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
		input logic [31:0] act_val);
		fail_run($sformatf("[FAIL] %0s %0s expected %h actual %h", cur_name, sig,
			exp_val, act_val));
	endtask

	// Run length is bounded from the table
	always @(posedge pll_afi_clk)
	begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > cycle_limit)
			fail_run($sformatf("Timeout, the tests did not finish within %0d cycles",
				cycle_limit));
	end

	// ****************************************
	// Reference model
	// ****************************************

	// A request at edge k sets valid after k+L+2, DQS enable after k+a+1,
	// and termination low after k+OCT_ON_DELAY through k+OCT_OFF_DELAY
	task automatic record_request();
		exp_valid[edge_cnt + int'(seq_read_latency_counter_i) + 2] = 1'b1;
		for (int g = 0; g < DQS_GROUPS; g++)
			exp_dqs[edge_cnt + vfifo_addr[g] + 1][g] = 1'b1;
		for (int d = OCT_ON_DELAY; d <= OCT_OFF_DELAY; d++)
			oct_low[edge_cnt + d] = 1'b1;
		request_total = request_total + 1;
	endtask

	always @(posedge pll_afi_clk)
	begin
		edge_cnt = edge_cnt + 1;
		for (int g = 0; g < DQS_GROUPS; g++)
		begin
			if (!reset_n_afi_clk)
			begin
				vfifo_addr[g] = 0;
				rd_ptr_m[g] = 0;
				wr_rst_n_m[g] = 1'b0;
			end
		end
		if (reset_n_afi_clk)
		begin
			if (afi_rdata_en_full_i)
				record_request();
			for (int g = 0; g < DQS_GROUPS; g++)
			begin
				// The output register loads the entry at the read pointer
				if (exp_valid[edge_cnt])
					snap[g] = model_mem[g][rd_ptr_m[g]];
				if (seq_read_fifo_reset_i[g])
					rd_ptr_m[g] = 0;
				else if (exp_valid[edge_cnt])
					rd_ptr_m[g] = (rd_ptr_m[g] + 1) % READ_FIFO_DEPTH;
				if (seq_read_increment_vfifo_i[g])
					vfifo_addr[g] = (vfifo_addr[g] + 1) % VFIFO_SPAN;
				wr_rst_n_m[g] = ~seq_read_fifo_reset_i[g];
			end
		end
	end

	// Every capture edge writes, the pointer only moves once the write reset is gone
	task automatic capture_word(input int g);
		if (!wr_rst_n_m[g])
			wr_ptr_m[g] = 0;
		model_mem[g][wr_ptr_m[g]] = ddio_phy_dq_i[g * DDIO_GROUP_WIDTH +: DDIO_GROUP_WIDTH];
		if (wr_rst_n_m[g])
			wr_ptr_m[g] = (wr_ptr_m[g] + 1) % READ_FIFO_DEPTH;
	endtask

	always @(posedge read_capture_clk_i[0]) capture_word(0);
	always @(posedge read_capture_clk_i[1]) capture_word(1);

	// Fresh capture data every cycle
	always @(negedge pll_afi_clk)
		ddio_phy_dq_i = ddio_data_t'($random(seed));

	// ****************************************
	// Checks and stimulus
	// ****************************************

	task automatic next_cycle();
		afi_data_t exp_afi;
		afi_data_t exp_q;
		@(negedge pll_afi_clk);
		assert (afi_rdata_valid_o === exp_valid[edge_cnt])
		else report_mismatch("afi_rdata_valid_o", exp_valid[edge_cnt], afi_rdata_valid_o);
		assert (dqs_enable_ctrl_o === exp_dqs[edge_cnt])
		else report_mismatch("dqs_enable_ctrl_o", exp_dqs[edge_cnt], dqs_enable_ctrl_o);
		assert (force_oct_off_o === ~oct_low[edge_cnt])
		else report_mismatch("force_oct_off_o", ~oct_low[edge_cnt], force_oct_off_o);
		if (exp_valid[edge_cnt])
		begin
			// AFI words by time slot then group, sequencer copy by group then time slot
			exp_afi = {snap[1][7:4], snap[0][7:4], snap[1][3:0], snap[0][3:0]};
			exp_q = {snap[1], snap[0]};
			assert (afi_rdata_o === exp_afi)
			else report_mismatch("afi_rdata_o", exp_afi, afi_rdata_o);
			assert (phy_mux_read_fifo_q_o === exp_q)
			else report_mismatch("phy_mux_read_fifo_q_o", exp_q, phy_mux_read_fifo_q_o);
			valid_seen = valid_seen + 1;
		end
	endtask

	task automatic set_request(input logic en);
		afi_rdata_en_i = en;
		afi_rdata_en_full_i = en;
	endtask

	task automatic add_row(input string name, input int lat, input int burst, input int inc0,
		input int inc1, input int gap, input int delay0, input int delay1);
		row_name[row_cnt] = name;
		row_lat[row_cnt] = lat;
		row_burst[row_cnt] = burst;
		row_inc0[row_cnt] = inc0;
		row_inc1[row_cnt] = inc1;
		row_gap[row_cnt] = gap;
		row_delay0[row_cnt] = delay0;
		row_delay1[row_cnt] = delay1;
		row_cnt = row_cnt + 1;
	endtask

	task automatic run_row(input int r);
		int pulses;
		cur_name = row_name[r];
		pulses = (row_inc0[r] > row_inc1[r]) ? row_inc0[r] : row_inc1[r];
		seq_read_latency_counter_i = lat_cnt_t'(row_lat[r]);
		set_request(1'b0);
		for (int i = 0; i < pulses; i++)
		begin
			seq_read_increment_vfifo_i = {i < row_inc1[r], i < row_inc0[r]};
			next_cycle();
		end
		seq_read_increment_vfifo_i = '0;
		assert (vfifo_addr[0] + 1 == row_delay0[r])
		else report_mismatch("group 0 DQS enable delay", row_delay0[r], vfifo_addr[0] + 1);
		assert (vfifo_addr[1] + 1 == row_delay1[r])
		else report_mismatch("group 1 DQS enable delay", row_delay1[r], vfifo_addr[1] + 1);
		for (int i = 0; i < row_burst[r]; i++)
		begin
			set_request(1'b1);
			next_cycle();
		end
		set_request(1'b0);
		for (int i = 0; i < row_gap[r]; i++)
			next_cycle();
	endtask

	initial
	begin
		seed = 14;
		reset_n_afi_clk = 1'b0;
		seq_read_fifo_reset_i = '1;
		seq_read_latency_counter_i = '0;
		seq_read_increment_vfifo_i = '0;
		set_request(1'b0);
		ddio_phy_dq_i = '0;
		for (int i = 0; i < EDGE_SLOTS; i++)
		begin
			exp_valid[i] = 1'b0;
			exp_dqs[i] = '0;
			oct_low[i] = 1'b0;
		end
		for (int g = 0; g < DQS_GROUPS; g++)
		begin
			wr_rst_n_m[g] = 1'b0;
			wr_ptr_m[g] = 0;
			rd_ptr_m[g] = 0;
			vfifo_addr[g] = 0;
		end
		//       name            lat burst inc0 inc1 gap d0 d1
		add_row("single_l4",      4,  1,    0,   0,  12, 1, 1);
		add_row("burst2_l6",      6,  2,    1,   2,  12, 2, 3);
		add_row("burst4_l9",      9,  4,    2,   3,   0, 4, 6);
		add_row("b2b_l9",         9,  3,    0,   0,  16, 4, 6);
		add_row("wrap_l2",        2,  2,    6,   5,  16, 2, 3);
		add_row("max_l15",       15,  4,    3,   0,  20, 5, 3);
		add_row("single_l0",      0,  1,    0,   1,   3, 5, 4);
		add_row("b2b_l0",         0,  3,    0,   0,   0, 5, 4);
		add_row("tail_l0",        0,  2,    1,   1,  10, 6, 5);
		for (int r = 0; r < NUM_ROWS; r++)
			cycle_limit = cycle_limit + row_burst[r] + MAX_READ_LATENCY + 8 + 10;
		repeat (5) @(negedge pll_afi_clk);
		assert ({afi_rdata_valid_o, dqs_enable_ctrl_o, force_oct_off_o} === '0)
		else report_mismatch("outputs in reset", 0,
			{afi_rdata_valid_o, dqs_enable_ctrl_o, force_oct_off_o});
		reset_n_afi_clk = 1'b1;
		seq_read_fifo_reset_i = '0;
		// Let every FIFO entry be written before the first read
		cur_name = "idle";
		repeat (10) next_cycle();
		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);
		cur_name = "drain";
		repeat (MAX_READ_LATENCY + 12) next_cycle();
		if (valid_seen == request_total)
		begin
			$display("sim passed");
			$finish;
		end
		else
			report_mismatch("valid cycle count", request_total, valid_seen);
	end

endmodule

`default_nettype wire

//--- sim/read_datapath_props.sv
// Assumes afi_rdata_en_i and afi_rdata_en_full_i are driven equal; checks hold only out of reset
`default_nettype none
`timescale 1ns/1ps

module read_datapath_props (
	input wire                          pll_afi_clk,
	input wire                          reset_n_afi_clk,
	input logic                         afi_rdata_en_full_i,
	input logic                         read_enable_i,
	input logic                         afi_rdata_valid_i,
	input read_datapath_pkg::afi_data_t afi_rdata_i,
	input read_datapath_pkg::afi_data_t fifo_q_i,
	input read_datapath_pkg::dqs_vec_t  dqs_enable_ctrl_i,
	input logic                         force_oct_off_i
);

	// ****************************************
	// Read datapath properties
	// ****************************************

	// Termination goes low on the edge after the request is sampled,
	// which the sampled value shows one edge later again
	oct_follows_request: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_en_full_i |-> ##2 !force_oct_off_i)
	else $error("Termination was not enabled after a full read request");

	// Valid trails the FIFO read strobe by exactly one cycle
	valid_follows_read: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		read_enable_i |=> afi_rdata_valid_i)
	else $error("Read valid did not follow the FIFO read enable");

	outputs_known: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		!$isunknown({afi_rdata_i, afi_rdata_valid_i, fifo_q_i, dqs_enable_ctrl_i,
		force_oct_off_i}))
	else $error("An output of the read datapath is unknown");

endmodule

bind read_datapath read_datapath_props read_datapath_props_i (
	.pll_afi_clk         (pll_afi_clk),
	.reset_n_afi_clk     (reset_n_afi_clk),
	.afi_rdata_en_full_i (afi_rdata_en_full_i),
	.read_enable_i       (read_enable),
	.afi_rdata_valid_i   (afi_rdata_valid_o),
	.afi_rdata_i         (afi_rdata_o),
	.fifo_q_i            (phy_mux_read_fifo_q_o),
	.dqs_enable_ctrl_i   (dqs_enable_ctrl_o),
	.force_oct_off_i     (force_oct_off_o)
);

`default_nettype wire

//--- design/read_datapath.sv
// Full rate DDR3 read path with two DQS groups; request strobes are expected on pll_afi_clk
`default_nettype none
`timescale 1ns/1ps

module read_datapath (
	input  wire                           pll_afi_clk,
	input  wire                           reset_n_afi_clk,
	input  read_datapath_pkg::dqs_vec_t   read_capture_clk_i,
	input  read_datapath_pkg::dqs_vec_t   seq_read_fifo_reset_i,
	input  read_datapath_pkg::lat_cnt_t   seq_read_latency_counter_i,
	input  read_datapath_pkg::dqs_vec_t   seq_read_increment_vfifo_i,
	input  logic                          afi_rdata_en_i,
	input  logic                          afi_rdata_en_full_i,
	input  read_datapath_pkg::ddio_data_t ddio_phy_dq_i,
	output read_datapath_pkg::afi_data_t  afi_rdata_o,
	output logic                          afi_rdata_valid_o,
	output read_datapath_pkg::afi_data_t  phy_mux_read_fifo_q_o,
	output read_datapath_pkg::dqs_vec_t   dqs_enable_ctrl_o,
	output logic                          force_oct_off_o
);

	// Shared FIFO read strobe, one per design since all groups see one latency
	logic read_enable;

	// ****************************************
	// Request decoding
	// ****************************************

	read_latency_fifo read_latency_fifo_i (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_i      (afi_rdata_en_i),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.latency_i           (seq_read_latency_counter_i),
		.read_enable_o       (read_enable),
		.afi_rdata_valid_o   (afi_rdata_valid_o)
	);

	oct_control oct_control_i (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_o     (force_oct_off_o)
	);

	// ****************************************
	// Per group FIFOs and data reordering
	// ****************************************

	genvar g;
	genvar t;

	for (g = 0; g < read_datapath_pkg::DQS_GROUPS; g++)
	begin : group_gen
		// This group's slice of the DDIO bus, time slot 1 in the upper half
		read_datapath_pkg::ddio_group_t group_capture;
		// Resynchronized data on the AFI clock, same layout as the capture slice
		read_datapath_pkg::ddio_group_t group_rdata;

		assign group_capture = ddio_phy_dq_i[g * read_datapath_pkg::DDIO_GROUP_WIDTH
			+: read_datapath_pkg::DDIO_GROUP_WIDTH];

		// Each group gets its own DQS enable delay, tuned by the sequencer
		valid_predict_fifo valid_predict_fifo_i (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.token_i         (afi_rdata_en_full_i),
			.increment_i     (seq_read_increment_vfifo_i[g]),
			.qvld_o          (dqs_enable_ctrl_o[g])
		);

		read_resync_fifo read_resync_fifo_i (
			.pll_afi_clk     (pll_afi_clk),
			.reset_n_afi_clk (reset_n_afi_clk),
			.capture_clk_i   (read_capture_clk_i[g]),
			.fifo_reset_i    (seq_read_fifo_reset_i[g]),
			.capture_data_i  (group_capture),
			.read_enable_i   (read_enable),
			.read_data_o     (group_rdata)
		);

		for (t = 0; t < read_datapath_pkg::TIMESLOTS; t++)
		begin : slot_gen
			read_datapath_pkg::dq_group_t slot_word;

			assign slot_word = group_rdata[t * read_datapath_pkg::DQ_GROUP_WIDTH
				+: read_datapath_pkg::DQ_GROUP_WIDTH];

			// AFI layout is by time slot, then by group: D1_T1 D0_T1 D1_T0 D0_T0
			assign afi_rdata_o[t * read_datapath_pkg::MEM_DQ_WIDTH
				+ g * read_datapath_pkg::DQ_GROUP_WIDTH
				+: read_datapath_pkg::DQ_GROUP_WIDTH] = slot_word;

			// Sequencer copy keeps each group together: D1_T1 D1_T0 D0_T1 D0_T0
			assign phy_mux_read_fifo_q_o[g * read_datapath_pkg::DDIO_GROUP_WIDTH
				+ t * read_datapath_pkg::DQ_GROUP_WIDTH
				+: read_datapath_pkg::DQ_GROUP_WIDTH] = slot_word;
		end
	end

endmodule

`default_nettype wire

//--- read_fifo/read_resync_fifo.sv
// The FIFO reset may only be released while the capture clock carries no read data
`default_nettype none
`timescale 1ns/1ps

module read_resync_fifo (
	input  wire                            pll_afi_clk,
	input  wire                            reset_n_afi_clk,
	input  logic                           capture_clk_i,
	input  logic                           fifo_reset_i,
	input  read_datapath_pkg::ddio_group_t capture_data_i,
	input  logic                           read_enable_i,
	output read_datapath_pkg::ddio_group_t read_data_o
);

	import read_datapath_pkg::*;

	// Pointer advance with wrap at the FIFO depth
	function automatic rfifo_addr_t next_ptr(input rfifo_addr_t ptr);
		if (ptr == rfifo_addr_t'(READ_FIFO_DEPTH - 1))
			return '0;
		return ptr + rfifo_addr_t'(1);
	endfunction

	// Flop memory, one entry per capture cycle
	ddio_group_t fifo_mem [READ_FIFO_DEPTH];

	// Write side runs on the capture clock, read side on the AFI clock
	rfifo_addr_t wr_ptr;
	rfifo_addr_t rd_ptr;

	// Active low write side reset, registered on the AFI clock
	logic reset_n_fifo_write;

	// ****************************************
	// Write side reset
	// ****************************************

	// Goes low with the system reset or with the sequencer's FIFO reset
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			reset_n_fifo_write <= 1'b0;
		else
			reset_n_fifo_write <= ~fifo_reset_i;
	end

	// ****************************************
	// Write side
	// ****************************************

	// The reset comes from the AFI domain and is asynchronous to the capture clock
	// The sequencer only releases it after the data path has been idle, when the
	// pointer sits at 0 on both sides of the register, so recovery is safe
	always_ff @(posedge capture_clk_i or negedge reset_n_fifo_write)
	begin
		if (!reset_n_fifo_write)
			wr_ptr <= '0;
		else
			wr_ptr <= next_ptr(wr_ptr);
	end

	// Every capture edge is written; the read side decides what is valid
	always_ff @(posedge capture_clk_i)
	begin
		fifo_mem[wr_ptr] <= capture_data_i;
	end

	// ****************************************
	// Read side
	// ****************************************

	// Cleared synchronously by the sequencer reset as well as by the system reset
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			rd_ptr <= '0;
		else if (fifo_reset_i)
			rd_ptr <= '0;
		else if (read_enable_i)
			rd_ptr <= next_ptr(rd_ptr);
	end

	// Output register loads one entry per read enable cycle
	// It updates on the same edge as the AFI read valid strobe
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			read_data_o <= '0;
		else if (read_enable_i)
			read_data_o <= fifo_mem[rd_ptr];
	end

endmodule

`default_nettype wire

//--- read_fifo/valid_predict_fifo.sv
// One DQS group on pll_afi_clk; the delay can only grow and wraps back after eight increments
`default_nettype none
`timescale 1ns/1ps

module valid_predict_fifo (
	input  wire  pll_afi_clk,
	input  wire  reset_n_afi_clk,
	input  logic token_i,
	input  logic increment_i,
	output logic qvld_o
);

	import read_datapath_pkg::*;

	// ****************************************
	// Write address
	// ****************************************

	// Tuned by the sequencer, one extra AFI cycle of delay per pulse
	vfifo_addr_t wr_addr;

	// Shifter position for the token; one bit wider so the extra stage never wraps
	logic [VFIFO_ADDR_WIDTH:0] wr_index;

	// Address wraps modulo the shifter's tunable span
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			wr_addr <= '0;
		else if (increment_i)
			wr_addr <= wr_addr + vfifo_addr_t'(1);
	end

	assign wr_index = {1'b0, wr_addr} + (VFIFO_ADDR_WIDTH + 1)'(QVLD_EXTRA_FLOP_STAGES);

	// ****************************************
	// Token shifter
	// ****************************************

	logic [QVLD_SHIFTER_LENGTH-1:0] qvld_shifter;
	logic [QVLD_SHIFTER_LENGTH-1:0] qvld_shifter_next;

	// Everything moves one place toward bit 0, then the new token or an empty
	// slot is dropped in at the write position
	always_comb
	begin
		qvld_shifter_next = {1'b0, qvld_shifter[QVLD_SHIFTER_LENGTH-1:1]};
		qvld_shifter_next[wr_index] = token_i;
	end

	// A token written at position a+1 reaches bit 0 after a+1 edges
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
			qvld_shifter <= '0;
		else
			qvld_shifter <= qvld_shifter_next;
	end

	// Bit 0 marks the cycle in which the group's DQS is expected to toggle
	assign qvld_o = qvld_shifter[0];

endmodule

`default_nettype wire

//--- design/oct_control.sv
// Single termination control for all groups; the window is fixed at build time by MEM_T_RL
`default_nettype none
`timescale 1ns/1ps

module oct_control (
	input  wire  pll_afi_clk,
	input  wire  reset_n_afi_clk,
	input  logic afi_rdata_en_full_i,
	output logic force_oct_off_o
);

	import read_datapath_pkg::*;

	// ****************************************
	// Request history
	// ****************************************

	// Bit 0 holds the request sampled one edge ago, the top bit OCT_OFF_DELAY edges ago
	logic [OCT_OFF_DELAY-1:0] rdata_en_hist;

	// Window index j means j edges earlier, index 0 is the request on the current edge
	logic [OCT_OFF_DELAY:0] rdata_en_window;

	assign rdata_en_window = {rdata_en_hist, afi_rdata_en_full_i};

	// ****************************************
	// Termination off level
	// ****************************************

	// Termination stays enabled while any request in the window is still pending
	// on the bus, and is forced off in every other cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_hist <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			rdata_en_hist <= {rdata_en_hist[OCT_OFF_DELAY-2:0], afi_rdata_en_full_i};
			// Window bounds are inclusive at both ends
			force_oct_off_o <= ~(|rdata_en_window[OCT_OFF_DELAY:OCT_ON_DELAY]);
		end
	end

endmodule

`default_nettype wire

//--- design/read_latency_fifo.sv
// Latency counter must be stable while reads are in flight; the largest usable value is 15
`default_nettype none
`timescale 1ns/1ps

module read_latency_fifo (
	input  wire                         pll_afi_clk,
	input  wire                         reset_n_afi_clk,
	input  logic                        afi_rdata_en_i,
	input  logic                        afi_rdata_en_full_i,
	input  read_datapath_pkg::lat_cnt_t latency_i,
	output logic                        read_enable_o,
	output logic                        afi_rdata_valid_o
);

	import read_datapath_pkg::*;

	// ****************************************
	// Request shift registers
	// ****************************************

	// Bit j holds the request that was sampled j edges before the last one
	logic [MAX_READ_LATENCY-1:0] valid_shift;
	logic [MAX_READ_LATENCY-1:0] full_shift;

	// First stage of the two stage valid path
	logic valid_sel_r;

	// Both strobes move one place per AFI cycle, new requests enter at bit 0
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			valid_shift <= '0;
			full_shift <= '0;
		end
		else
		begin
			valid_shift <= {valid_shift[MAX_READ_LATENCY-2:0], afi_rdata_en_i};
			full_shift <= {full_shift[MAX_READ_LATENCY-2:0], afi_rdata_en_full_i};
		end
	end

	// ****************************************
	// Latency selection
	// ****************************************

	// The calibrated latency picks one tap for both paths
	// The full path feeds the FIFO read side one cycle ahead of the valid strobe,
	// so the FIFO output register and afi_rdata_valid_o change on the same edge
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_enable_o <= 1'b0;
			valid_sel_r <= 1'b0;
			afi_rdata_valid_o <= 1'b0;
		end
		else
		begin
			read_enable_o <= full_shift[latency_i];
			valid_sel_r <= valid_shift[latency_i];
			// Second register lines valid up with the registered FIFO data
			afi_rdata_valid_o <= valid_sel_r;
		end
	end

endmodule

`default_nettype wire

//--- common/read_datapath_pkg.sv
// Full rate, two read DQS groups only; changing a size here does not add half or quarter rate
`default_nettype none

package read_datapath_pkg;

	// ****************************************
	// Interface sizes
	// ****************************************

	// Two read DQS groups of four DQ each
	localparam int DQS_GROUPS = 2;
	localparam int DQ_GROUP_WIDTH = 4;
	localparam int MEM_DQ_WIDTH = DQS_GROUPS * DQ_GROUP_WIDTH;

	// At full rate the DDIO hands over two time slots per AFI cycle
	localparam int TIMESLOTS = 2;
	localparam int DDIO_GROUP_WIDTH = TIMESLOTS * DQ_GROUP_WIDTH;
	localparam int AFI_DATA_WIDTH = TIMESLOTS * MEM_DQ_WIDTH;

	// ****************************************
	// Latency and FIFO sizing
	// ****************************************

	// The latency counter selects a tap of a 16 bit request shift register
	localparam int MAX_READ_LATENCY = 16;
	localparam int LAT_CNT_WIDTH = 4;

	// Resynchronization FIFO, a power of two so the pointers wrap on their own
	localparam int READ_FIFO_DEPTH = 8;
	localparam int READ_FIFO_ADDR_WIDTH = 3;

	// Valid prediction shifter, eight tunable positions plus the fixed extra stage
	localparam int VFIFO_ADDR_WIDTH = 3;
	localparam int QVLD_EXTRA_FLOP_STAGES = 1;
	localparam int QVLD_SHIFTER_LENGTH = (2 ** VFIFO_ADDR_WIDTH) + QVLD_EXTRA_FLOP_STAGES;

	// ****************************************
	// Termination window
	// ****************************************

	// The window is derived from the memory read latency, in AFI cycles
	localparam int MEM_T_RL = 7;
	localparam int OCT_ON_DELAY = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY = (MEM_T_RL + 6) / 2;

	// ****************************************
	// Types
	// ****************************************

	typedef logic [DQS_GROUPS-1:0] dqs_vec_t;
	typedef logic [DQ_GROUP_WIDTH-1:0] dq_group_t;
	// Time slot 1 sits in the upper half
	typedef logic [DDIO_GROUP_WIDTH-1:0] ddio_group_t;
	// Ordered by group, each group sub-ordered by time slot
	typedef logic [DQS_GROUPS*DDIO_GROUP_WIDTH-1:0] ddio_data_t;
	typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;
	typedef logic [LAT_CNT_WIDTH-1:0] lat_cnt_t;
	typedef logic [VFIFO_ADDR_WIDTH-1:0] vfifo_addr_t;
	typedef logic [READ_FIFO_ADDR_WIDTH-1:0] rfifo_addr_t;

endpackage

`default_nettype wire
